// File: flist.f
hdl/rr_pkg.sv
hdl/log_decoder.sv
hdl/replay_fifo.sv
hdl/twowayhandshake_replayer.sv
hdl/replay_top.sv
test/tb_replay_top.sv

// File: hdl/log_decoder.sv
//////////////////////////////
// log word decoder, routes entries to per-channel fifos
//////////////////////////////
`timescale 1ns/1ps

module log_decoder (
  // packed log stream
  input  logic                i_log_valid,
  input  rr_pkg::log_word_t   i_log_word,
  output logic                o_log_ready,
  // per-channel push side
  output rr_pkg::loge_vec_t   o_push_valid,
  output logic                o_push_logb_valid,
  output rr_pkg::logb_data_t  o_push_logb_data,
  output rr_pkg::loge_vec_t   o_push_loge_valid,
  input  rr_pkg::loge_vec_t   i_push_ready
);

  import rr_pkg::*;

  // channel named by the current word
  ch_id_t ch_id;

  //////////////////////////////
  // field extraction
  //////////////////////////////
  // channel index sits in the top bits
  assign ch_id = i_log_word[LOG_WORD_WIDTH-1 -: CH_ID_WIDTH];

  // payload valid right below the channel index
  assign o_push_logb_valid = i_log_word[DATA_WIDTH + LOGE_CHANNEL_CNT];

  // payload between valid bit and loge vector
  assign o_push_logb_data = i_log_word[LOGE_CHANNEL_CNT +: DATA_WIDTH];

  // transaction-end marks in the low bits
  assign o_push_loge_valid = i_log_word[LOGE_CHANNEL_CNT-1:0];

  //////////////////////////////
  // routing
  //////////////////////////////
  // only the named channel sees a push, data fields are shared
  always_comb begin
    o_push_valid = '0;
    o_push_valid[ch_id] = i_log_valid;
  end

  // stall the whole stream while the named fifo is full
  // keeps per-channel order since nothing is skipped
  assign o_log_ready = i_push_ready[ch_id];

endmodule

// File: hdl/replay_fifo.sv
//////////////////////////////
// per-channel replay entry fifo
//////////////////////////////
`timescale 1ns/1ps

module replay_fifo (
  input  logic                clk,
  input  logic                rstn,
  // push side, from the decoder
  input  logic                i_push_valid,
  output logic                o_push_ready,
  input  logic                i_logb_valid,
  input  rr_pkg::logb_data_t  i_logb_data,
  input  rr_pkg::loge_vec_t   i_loge_valid,
  // pop side, head entry to the replayer
  output logic                o_pop_valid,
  input  logic                i_pop_ready,
  output logic                o_logb_valid,
  output rr_pkg::logb_data_t  o_logb_data,
  output rr_pkg::loge_vec_t   o_loge_valid
);

  import rr_pkg::*;

  // entry storage, split by field
  logic       mem_logb_valid [REPLAY_FIFO_DEPTH];
  logb_data_t mem_logb_data  [REPLAY_FIFO_DEPTH];
  loge_vec_t  mem_loge_valid [REPLAY_FIFO_DEPTH];

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;
  fifo_cnt_t count_next;
  logic      push;
  logic      pop;

  assign push = i_push_valid && o_push_ready;
  assign pop  = o_pop_valid && i_pop_ready;

  // occupancy after this edge, push and pop may overlap
  assign count_next = count + fifo_cnt_t'(push) - fifo_cnt_t'(pop);

  //////////////////////////////
  // pointers and occupancy
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      o_push_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == fifo_ptr_t'(REPLAY_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == fifo_ptr_t'(REPLAY_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      // ready drops right after the edge that fills the last slot
      o_push_ready <= (count_next != fifo_cnt_t'(REPLAY_FIFO_DEPTH));
    end
  end

  // storage write
  always_ff @(posedge clk) begin
    if (push) begin
      mem_logb_valid[wr_ptr] <= i_logb_valid;
      mem_logb_data[wr_ptr] <= i_logb_data;
      mem_loge_valid[wr_ptr] <= i_loge_valid;
    end
  end

  // head straight from storage
  assign o_pop_valid  = (count != '0);
  assign o_logb_valid = mem_logb_valid[rd_ptr];
  assign o_logb_data  = mem_logb_data[rd_ptr];
  assign o_loge_valid = mem_loge_valid[rd_ptr];

endmodule

// File: hdl/replay_top.sv
//////////////////////////////
// replay top, decoder plus two channel paths
//////////////////////////////
`timescale 1ns/1ps

module replay_top (
  input  logic                clk,
  input  logic                rstn,
  // packed log stream
  input  logic                i_log_valid,
  input  rr_pkg::log_word_t   i_log_word,
  output logic                o_log_ready,
  // runtime transaction ends
  input  rr_pkg::loge_vec_t   i_rt_loge_valid,
  // replayed payloads, one stream per channel
  output rr_pkg::loge_vec_t   o_out_valid,
  input  rr_pkg::loge_vec_t   i_out_ready,
  output rr_pkg::logb_data_t  o_out_data0,
  output rr_pkg::logb_data_t  o_out_data1
);

  import rr_pkg::*;

  // decoder to fifos
  loge_vec_t  push_valid;
  loge_vec_t  push_ready;
  logic       push_logb_valid;
  logb_data_t push_logb_data;
  loge_vec_t  push_loge_valid;

  // fifo heads to replayers
  loge_vec_t  head_valid;
  loge_vec_t  head_ready;
  loge_vec_t  head_logb_valid;
  logb_data_t head_logb_data  [LOGE_CHANNEL_CNT];
  loge_vec_t  head_loge_valid [LOGE_CHANNEL_CNT];
  logb_data_t out_data        [LOGE_CHANNEL_CNT];

  log_decoder u_decoder (
    .i_log_valid       (i_log_valid),
    .i_log_word        (i_log_word),
    .o_log_ready       (o_log_ready),
    .o_push_valid      (push_valid),
    .o_push_logb_valid (push_logb_valid),
    .o_push_logb_data  (push_logb_data),
    .o_push_loge_valid (push_loge_valid),
    .i_push_ready      (push_ready)
  );

  // one fifo and one replayer per channel
  for (genvar c = 0; c < LOGE_CHANNEL_CNT; c++) begin : g_ch
    replay_fifo u_fifo (
      .clk          (clk),
      .rstn         (rstn),
      .i_push_valid (push_valid[c]),
      .o_push_ready (push_ready[c]),
      .i_logb_valid (push_logb_valid),
      .i_logb_data  (push_logb_data),
      .i_loge_valid (push_loge_valid),
      .o_pop_valid  (head_valid[c]),
      .i_pop_ready  (head_ready[c]),
      .o_logb_valid (head_logb_valid[c]),
      .o_logb_data  (head_logb_data[c]),
      .o_loge_valid (head_loge_valid[c])
    );

    twowayhandshake_replayer u_replayer (
      .clk             (clk),
      .rstn            (rstn),
      .i_in_valid      (head_valid[c]),
      .i_logb_valid    (head_logb_valid[c]),
      .i_logb_data     (head_logb_data[c]),
      .i_loge_valid    (head_loge_valid[c]),
      .o_in_ready      (head_ready[c]),
      .i_rt_loge_valid (i_rt_loge_valid),
      .o_out_valid     (o_out_valid[c]),
      .i_out_ready     (i_out_ready[c]),
      .o_out_data      (out_data[c])
    );
  end

  assign o_out_data0 = out_data[0];
  assign o_out_data1 = out_data[1];

endmodule

// File: hdl/rr_pkg.sv
//////////////////////////////
// widths, depths and types shared by the replay path
//////////////////////////////
package rr_pkg;

  // payload and channel sizing
  localparam int DATA_WIDTH = 16;
  localparam int LOGE_CHANNEL_CNT = 2;
  localparam int CH_ID_WIDTH = 1;

  // buffering along one channel
  localparam int REPLAY_FIFO_DEPTH = 4;
  localparam int REPLAYER_PIPE_DEPTH = 2;
  localparam int FIFO_PTR_WIDTH = $clog2(REPLAY_FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH = $clog2(REPLAY_FIFO_DEPTH + 1);

  // worst runtime/replay gap: fifo + replayer stages + decoder stage
  localparam int ON_THE_FLY_CNT = REPLAY_FIFO_DEPTH + REPLAYER_PIPE_DEPTH + 1;
  // the gap has to stay within half of the counter circle
  localparam int PKT_CNT_WIDTH = $clog2(2 * ON_THE_FLY_CNT);

  // {ch_id, logb_valid, logb_data, loge_vec}
  localparam int LOG_WORD_WIDTH = CH_ID_WIDTH + 1 + DATA_WIDTH + LOGE_CHANNEL_CNT;

  typedef logic [DATA_WIDTH-1:0] logb_data_t;
  typedef logic [LOGE_CHANNEL_CNT-1:0] loge_vec_t;
  typedef logic [CH_ID_WIDTH-1:0] ch_id_t;
  typedef logic [LOG_WORD_WIDTH-1:0] log_word_t;
  typedef logic [PKT_CNT_WIDTH-1:0] pkt_cnt_t;
  typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_WIDTH-1:0] fifo_cnt_t;

  // skid buffer occupancy of the replayer
  typedef enum logic [1:0] {
    EMPTY,
    BUSY,
    FULL
  } replay_state_t;

endpackage

// File: hdl/twowayhandshake_replayer.sv
//////////////////////////////
// replayer, skid buffer plus happen-before counters
//////////////////////////////
`timescale 1ns/1ps

module twowayhandshake_replayer (
  input  logic                clk,
  input  logic                rstn,
  // replay entries from the fifo
  input  logic                i_in_valid,
  input  logic                i_logb_valid,
  input  rr_pkg::logb_data_t  i_logb_data,
  input  rr_pkg::loge_vec_t   i_loge_valid,
  output logic                o_in_ready,
  // runtime transaction ends, never stalled
  input  rr_pkg::loge_vec_t   i_rt_loge_valid,
  // replayed payloads
  output logic                o_out_valid,
  input  logic                i_out_ready,
  output rr_pkg::logb_data_t  o_out_data
);

  import rr_pkg::*;

  replay_state_t state;
  replay_state_t state_next;

  // skid register, holds the entry behind the output one
  logic       skid_logb_valid;
  logb_data_t skid_logb_data;
  loge_vec_t  skid_loge_valid;

  // output register
  logic       obuf_logb_valid;
  logic       obuf_logb_valid_next;
  logb_data_t obuf_logb_data;

  logic insert;
  logic remove;
  logic remove_logb;
  logic remove_loge;

  // runtime count minus replay count, one per channel
  pkt_cnt_t  cnt      [LOGE_CHANNEL_CNT];
  pkt_cnt_t  cnt_next [LOGE_CHANNEL_CNT];
  loge_vec_t cnt_sign;
  logic      ok_to_replay;

  //////////////////////////////
  // handshakes
  //////////////////////////////
  assign insert = i_in_valid && o_in_ready;
  // payload handed to the runtime
  assign remove_logb = o_out_valid && i_out_ready;
  // loge-only entry leaves after one cycle
  assign remove_loge = (state != EMPTY) && !obuf_logb_valid;
  assign remove = remove_logb || remove_loge;

  //////////////////////////////
  // fsm
  //////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      EMPTY: begin
        // load
        if (insert) begin
          state_next = BUSY;
        end
      end
      BUSY: begin
        // fill when only inserting, unload when only removing
        // flow or idle keeps BUSY
        if (insert && !remove) begin
          state_next = FULL;
        end else if (!insert && remove) begin
          state_next = EMPTY;
        end
      end
      FULL: begin
        // flush skid into the output register
        if (remove) begin
          state_next = BUSY;
        end
      end
      default: begin
        state_next = EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= EMPTY;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////
  // data path
  //////////////////////////////
  // skid loads when a new entry arrives but the output is still busy
  always_ff @(posedge clk) begin
    if ((state == BUSY) && (state_next == FULL)) begin
      skid_logb_valid <= i_logb_valid;
      skid_logb_data <= i_logb_data;
      skid_loge_valid <= i_loge_valid;
    end
  end

  // output register takes the skid first, else the input on load or flow
  always_comb begin
    obuf_logb_valid_next = obuf_logb_valid;
    if (state_next == BUSY) begin
      if (state == FULL) begin
        obuf_logb_valid_next = skid_logb_valid;
      end else if (insert) begin
        obuf_logb_valid_next = i_logb_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_next == BUSY) begin
      if (state == FULL) begin
        obuf_logb_data <= skid_logb_data;
      end else if (insert) begin
        obuf_logb_data <= i_logb_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      obuf_logb_valid <= 1'b0;
    end else begin
      obuf_logb_valid <= obuf_logb_valid_next;
    end
  end

  //////////////////////////////
  // happen-before counters
  //////////////////////////////
  // runtime pulses add, loge bits subtract as the entry enters the output register
  // the entry's own loge marks count against its payload
  for (genvar i = 0; i < LOGE_CHANNEL_CNT; i++) begin : g_cnt
    always_comb begin
      cnt_next[i] = cnt[i] + pkt_cnt_t'(i_rt_loge_valid[i]);
      if (state_next == BUSY) begin
        if (state == FULL) begin
          cnt_next[i] = cnt_next[i] - pkt_cnt_t'(skid_loge_valid[i]);
        end else if (insert) begin
          cnt_next[i] = cnt_next[i] - pkt_cnt_t'(i_loge_valid[i]);
        end
      end
    end

    always_ff @(posedge clk) begin
      if (!rstn) begin
        cnt[i] <= '0;
      end else begin
        cnt[i] <= cnt_next[i];
      end
    end

    // sign set means the runtime is still behind on this channel
    assign cnt_sign[i] = cnt_next[i][PKT_CNT_WIDTH-1];
  end

  assign ok_to_replay = !(|cnt_sign);

  //////////////////////////////
  // registered outputs
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_out_valid <= 1'b0;
      o_in_ready <= 1'b0;
    end else begin
      o_out_valid <= (state_next != EMPTY) && obuf_logb_valid_next && ok_to_replay;
      // no room once both stages are taken
      o_in_ready <= (state_next != FULL);
    end
  end

  assign o_out_data = obuf_logb_data;

endmodule

// File: test/tb_replay_top.sv
//////////////////////////////
// testbench for replay_top, directed tests with scoreboard
//////////////////////////////
`timescale 1ns/1ps

module tb_replay_top;

  import rr_pkg::*;

  localparam int CLK_PERIOD = 20;
  // 6 tests, at most 834 cycles each, doubled for margin
  localparam int TEST_CNT = 6;
  localparam int TEST_WORST_CYCLES = 834;
  localparam int WATCHDOG_NS = TEST_CNT * TEST_WORST_CYCLES * CLK_PERIOD * 2;
  localparam int WAIT_LIMIT = 500;
  localparam int RAND_WORDS = 60;

  // expected payload and replay loge counts up to and including it
  typedef struct packed {
    logb_data_t                         data;
    logic [LOGE_CHANNEL_CNT-1:0] [15:0] need;
  } exp_entry_t;

  logic       clk;
  logic       rstn;
  logic       i_log_valid;
  log_word_t  i_log_word;
  logic       o_log_ready;
  loge_vec_t  i_rt_loge_valid;
  loge_vec_t  o_out_valid;
  loge_vec_t  i_out_ready;
  logb_data_t o_out_data0;
  logb_data_t o_out_data1;

  // scoreboard queues and runtime model
  exp_entry_t exp_q [LOGE_CHANNEL_CNT][$];
  int         rt_cnt [LOGE_CHANNEL_CNT];
  int         acc_cnt [LOGE_CHANNEL_CNT][LOGE_CHANNEL_CNT];
  int         words_accepted;
  int         errors;
  loge_vec_t  prev_stall;
  logb_data_t prev_data [LOGE_CHANNEL_CNT];
  // fields of the word currently on the log stream
  ch_id_t     pend_ch;
  logic       pend_lv;
  logb_data_t pend_data;
  loge_vec_t  pend_le;
  logic       rand_mode;
  int         seed;
  int         ctl_seed;

  replay_top UUT (
    .clk             (clk),
    .rstn            (rstn),
    .i_log_valid     (i_log_valid),
    .i_log_word      (i_log_word),
    .o_log_ready     (o_log_ready),
    .i_rt_loge_valid (i_rt_loge_valid),
    .o_out_valid     (o_out_valid),
    .i_out_ready     (i_out_ready),
    .o_out_data0     (o_out_data0),
    .o_out_data1     (o_out_data1)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // failure reporting
  //////////////////////////////
  task automatic value_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run($sformatf("timeout, the tests did not finish within %0d ns", WATCHDOG_NS));
  end

  // larger replay count of a runtime channel over both streams
  function automatic int max_replay(input int j);
    return (acc_cnt[0][j] > acc_cnt[1][j]) ? acc_cnt[0][j] : acc_cnt[1][j];
  endfunction

  //////////////////////////////
  // scoreboard, sampled on the rising edge
  //////////////////////////////
  always @(posedge clk) begin : scoreboard
    logb_data_t data;
    exp_entry_t head;
    if (rstn) begin
      for (int c = 0; c < LOGE_CHANNEL_CNT; c++) begin
        data = (c == 0) ? o_out_data0 : o_out_data1;
        // a stalled output holds valid and data
        if (prev_stall[c]) begin
          assert (o_out_valid[c] && (data == prev_data[c])) else
            value_error($sformatf("channel %0d output changed while stalled", c));
        end
        if (o_out_valid[c] && i_out_ready[c]) begin
          assert (exp_q[c].size() != 0) else
            value_error($sformatf("channel %0d sent unexpected payload %h", c, data));
          head = exp_q[c].pop_front();
          assert (data == head.data) else
            value_error($sformatf("channel %0d data %h, expected %h", c, data, head.data));
          // happen-before, runtime must have caught up on every channel
          for (int j = 0; j < LOGE_CHANNEL_CNT; j++) begin
            assert (rt_cnt[j] >= head.need[j]) else
              value_error($sformatf("channel %0d released %h with runtime %0d of %0d on ch %0d",
                                    c, data, rt_cnt[j], head.need[j], j));
          end
        end
        prev_stall[c] = o_out_valid[c] && !i_out_ready[c];
        prev_data[c] = data;
      end
      // accepted log word updates the replay counts
      if (i_log_valid && o_log_ready) begin
        for (int j = 0; j < LOGE_CHANNEL_CNT; j++) begin
          acc_cnt[pend_ch][j] += pend_le[j];
          head.need[j] = acc_cnt[pend_ch][j];
        end
        head.data = pend_data;
        if (pend_lv) begin
          exp_q[pend_ch].push_back(head);
        end
        words_accepted++;
      end
      for (int j = 0; j < LOGE_CHANNEL_CNT; j++) begin
        if (i_rt_loge_valid[j]) begin
          rt_cnt[j]++;
        end
      end
    end
  end

  // random ready pattern and runtime pulses, never ahead of the log
  always @(negedge clk) begin : random_drive
    int r;
    if (rand_mode) begin
      r = $random(ctl_seed);
      i_out_ready = r[1:0] | r[3:2];
      for (int j = 0; j < LOGE_CHANNEL_CNT; j++) begin
        i_rt_loge_valid[j] = r[4 + j] && (rt_cnt[j] < max_replay(j));
      end
    end
  end

  //////////////////////////////
  // drive helpers, all start and end on a falling edge
  //////////////////////////////
  task automatic drive_word(input ch_id_t ch, input logic lv, input logb_data_t d,
                            input loge_vec_t le, input int limit, output bit done);
    int start;
    int n;
    start = words_accepted;
    pend_ch = ch;
    pend_lv = lv;
    pend_data = d;
    pend_le = le;
    i_log_word = {ch, lv, d, le};
    i_log_valid = 1'b1;
    done = 1'b0;
    n = 0;
    while (!done && (n < limit)) begin
      @(negedge clk);
      n++;
      done = (words_accepted != start);
    end
    if (done) begin
      i_log_valid = 1'b0;
    end
  endtask

  task automatic send_word(input ch_id_t ch, input logic lv, input logb_data_t d,
                           input loge_vec_t le);
    bit done;
    drive_word(ch, lv, d, le, WAIT_LIMIT, done);
    assert (done) else abort_run("a log word was never accepted by the DUT");
  endtask

  task automatic pulse_rt(input loge_vec_t v);
    i_rt_loge_valid = v;
    @(negedge clk);
    i_rt_loge_valid = '0;
  endtask

  task automatic expect_held(input int c, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (!o_out_valid[c]) else
        value_error($sformatf("channel %0d released before its runtime pulses", c));
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q[0].size() != 0) || (exp_q[1].size() != 0)) begin
      @(negedge clk);
      n++;
      assert (n < WAIT_LIMIT) else abort_run("payloads did not drain from the replay outputs");
    end
    // idle cycles so a stray output still shows up
    repeat (5) @(negedge clk);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic check_reset();
    rstn = 1'b0;
    repeat (5) begin
      @(negedge clk);
      assert ((o_out_valid == '0) && !o_log_ready) else
        value_error("outputs active during reset");
    end
    rstn = 1'b1;
    @(negedge clk);
    assert ((o_out_valid == '0) && o_log_ready) else
      value_error("log ready did not rise after reset");
  endtask

  task automatic check_passthrough();
    i_out_ready = 2'b11;
    for (int k = 0; k < 8; k++) begin
      send_word(ch_id_t'(k % 2), 1'b1, logb_data_t'(16'h1000 + k), 2'b00);
    end
    wait_drain();
  endtask

  task automatic check_hb_hold();
    // channel 1 payload waits for one channel 0 runtime end
    send_word(1'b1, 1'b1, 16'hbeef, 2'b01);
    expect_held(1, 20);
    pulse_rt(2'b01);
    wait_drain();
  endtask

  task automatic check_loge_only();
    send_word(1'b0, 1'b0, 16'h0000, 2'b10);
    send_word(1'b0, 1'b0, 16'h0000, 2'b10);
    send_word(1'b0, 1'b1, 16'h1234, 2'b00);
    expect_held(0, 20);
    pulse_rt(2'b10);
    expect_held(0, 10);
    pulse_rt(2'b10);
    wait_drain();
  endtask

  task automatic check_backpressure();
    bit done;
    int k;
    done = 1'b1;
    k = 0;
    i_out_ready = 2'b10;
    // push until replayer and fifo of channel 0 are both full
    while (done && (k < 12)) begin
      drive_word(1'b0, 1'b1, logb_data_t'(16'h5000 + k), 2'b00, 10, done);
      k++;
    end
    assert (!done && !o_log_ready) else value_error("log ready never fell under back-pressure");
    repeat (10) @(negedge clk);
    i_out_ready = 2'b11;
    // the stalled word is still on the stream
    send_word(1'b0, 1'b1, logb_data_t'(16'h5000 + k - 1), 2'b00);
    wait_drain();
  endtask

  task automatic check_random();
    int r;
    ch_id_t ch;
    loge_vec_t le;
    loge_vec_t v;
    @(posedge clk);
    rand_mode = 1'b1;
    @(negedge clk);
    for (int k = 0; k < RAND_WORDS; k++) begin
      r = $random(seed);
      ch = r[0];
      le = r[4:3];
      // keep every replayer counter inside half of its circle
      for (int j = 0; j < LOGE_CHANNEL_CNT; j++) begin
        if ((acc_cnt[ch][j] + 1 - acc_cnt[ch ^ 1'b1][j] > 2) ||
            (acc_cnt[ch][j] + 1 - rt_cnt[j] > 6)) begin
          le[j] = 1'b0;
        end
      end
      send_word(ch, r[2:1] != 2'b00, r[31:16], le);
    end
    @(posedge clk);
    rand_mode = 1'b0;
    @(negedge clk);
    i_out_ready = 2'b11;
    i_rt_loge_valid = '0;
    // remaining runtime ends, up to the replay counts
    do begin
      for (int j = 0; j < LOGE_CHANNEL_CNT; j++) begin
        v[j] = rt_cnt[j] < max_replay(j);
      end
      if (v != '0) begin
        pulse_rt(v);
      end
    end while (v != '0);
    wait_drain();
  endtask

  initial begin : main
    clk = 1'b0;
    rstn = 1'b0;
    i_log_valid = 1'b0;
    i_log_word = '0;
    i_rt_loge_valid = '0;
    i_out_ready = '0;
    seed = 32'h50698930;
    ctl_seed = ~seed;
    errors = 0;
    words_accepted = 0;
    rand_mode = 1'b0;
    prev_stall = '0;
    for (int c = 0; c < LOGE_CHANNEL_CNT; c++) begin
      rt_cnt[c] = 0;
      prev_data[c] = '0;
      for (int j = 0; j < LOGE_CHANNEL_CNT; j++) begin
        acc_cnt[c][j] = 0;
      end
    end
    check_reset();
    check_passthrough();
    check_hb_hold();
    check_loge_only();
    check_backpressure();
    check_random();
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
